// ==== dv/csr_file_sva.sv ====
// --------------------
// bound checks on the CSR file outputs
// --------------------
`timescale 1ns/1ps

module csr_file_sva import csr_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      illegal_i,
  input logic      save_cause_i,
  input logic      mret_i,
  input csr_data_t mtvec_i,
  input csr_data_t mepc_i,
  input logic      mstatus_mie_i,
  input logic      irq_pending_i
);

  // illegal access alone moves nothing
  illegal_no_change: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (illegal_i && !save_cause_i && !mret_i) |=>
      ($stable(mtvec_i) && $stable(mepc_i) && $stable(mstatus_mie_i)))
    else $error("illegal access changed a register output");

  mtvec_mode: assert property (@(posedge clk_i) disable iff (!rst_ni) mtvec_i[1:0] == 2'b01)
    else $error("mtvec mode bits not 01");

  mepc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni) mepc_i[0] == 1'b0)
    else $error("mepc bit 0 set");

  no_irq_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !irq_pending_i)
    else $error("irq_pending_o high during reset");

endmodule

bind csr_file_top csr_file_sva u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .illegal_i     (illegal_csr_o),
  .save_cause_i  (csr_save_cause_i),
  .mret_i        (csr_restore_mret_i),
  .mtvec_i       (csr_mtvec_o),
  .mepc_i        (csr_mepc_o),
  .mstatus_mie_i (csr_mstatus_mie_o),
  .irq_pending_i (irq_pending_o)
);

// ==== dv/csr_file_tb.sv ====
// --------------------
// CSR file testbench driving seeded random access sequences
// all comparing happens in the scoreboard
// --------------------
`timescale 1ns/1ps

module csr_file_tb import csr_pkg::*; ;

  logic      clk, rst_n;
  csr_data_t hart_id;
  logic      csr_access;
  csr_addr_t csr_addr;
  csr_op_e   csr_op;
  csr_data_t csr_wdata, csr_rdata;
  logic      illegal_csr;
  logic      irq_sw, irq_tm, irq_ext, irq_pending;
  fast_irq_t irq_fast;
  logic      save_cause, mret, instr_ret;
  mcause_t   mcause;
  csr_data_t mtval, pc, mtvec, mepc;
  logic      mstatus_mie;
  int        err_count, check_count;
  int        tests_run = 0;
  int        tests_failed = 0;

  csr_addr_t rw_addrs [7] = '{CSR_MSCRATCH, CSR_MEPC, CSR_MTVAL, CSR_MTVEC,
                              CSR_MCAUSE, CSR_MIE, CSR_MSTATUS};
  csr_addr_t all_addrs [15] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
                               CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL,
                               CSR_MIP, CSR_MCOUNTINHIBIT, CSR_MCYCLE, CSR_MCYCLEH,
                               CSR_MINSTRET, CSR_MINSTRETH, CSR_MHARTID};

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  csr_file_top csr_file_top_i (
    .clk_i (clk), .rst_ni (rst_n), .hart_id_i (hart_id),
    .csr_access_i (csr_access), .csr_addr_i (csr_addr), .csr_op_i (csr_op),
    .csr_wdata_i (csr_wdata), .csr_rdata_o (csr_rdata), .illegal_csr_o (illegal_csr),
    .irq_software_i (irq_sw), .irq_timer_i (irq_tm), .irq_external_i (irq_ext),
    .irq_fast_i (irq_fast), .irq_pending_o (irq_pending),
    .csr_save_cause_i (save_cause), .csr_mcause_i (mcause), .csr_mtval_i (mtval),
    .pc_i (pc), .csr_restore_mret_i (mret), .instr_ret_i (instr_ret),
    .csr_mtvec_o (mtvec), .csr_mepc_o (mepc), .csr_mstatus_mie_o (mstatus_mie)
  );

  csr_scoreboard u_scoreboard (
    .clk_i (clk), .rst_ni (rst_n), .hart_id_i (hart_id),
    .csr_access_i (csr_access), .csr_addr_i (csr_addr), .csr_op_i (csr_op),
    .csr_wdata_i (csr_wdata), .csr_rdata_i (csr_rdata), .illegal_csr_i (illegal_csr),
    .irq_software_i (irq_sw), .irq_timer_i (irq_tm), .irq_external_i (irq_ext),
    .irq_fast_i (irq_fast), .irq_pending_i (irq_pending),
    .csr_save_cause_i (save_cause), .csr_mcause_i (mcause), .csr_mtval_i (mtval),
    .pc_i (pc), .csr_restore_mret_i (mret), .instr_ret_i (instr_ret),
    .csr_mtvec_i (mtvec), .csr_mepc_i (mepc), .csr_mstatus_mie_i (mstatus_mie),
    .err_count_o (err_count), .check_count_o (check_count)
  );

  function automatic csr_data_t rand_word();
    csr_data_t w;
    w = $urandom();
    return w;
  endfunction

  function automatic logic rand_bit();
    csr_data_t w;
    w = $urandom();
    return w[0];
  endfunction

  function automatic logic is_mapped(input csr_addr_t a);
    foreach (all_addrs[i]) begin
      if (all_addrs[i] == a) return 1'b1;
    end
    return 1'b0;
  endfunction

  // --------------------
  // one cycle of stimulus driven 2 ns after the edge
  task automatic drive_cycle(input logic acc, input csr_op_e op, input csr_addr_t addr,
                             input csr_data_t wd, input logic save, input logic ret_m,
                             input logic ret_i);
    @(posedge clk);
    #2;
    csr_access = acc;
    csr_op     = op;
    csr_addr   = addr;
    csr_wdata  = wd;
    save_cause = save;
    mret       = ret_m;
    instr_ret  = ret_i;
  endtask

  task automatic csr_cmd(input csr_op_e op, input csr_addr_t addr, input csr_data_t wd);
    drive_cycle(1'b1, op, addr, wd, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, CSR_OP_READ, '0, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    idle_cycles(1);   // let the last access be checked
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %-18s PASS", name);
    end else begin
      tests_failed++;
      $display("test %-18s FAIL, %0d mismatches", name, err_count - errs_before);
    end
  endtask

  // --------------------
  // test sequences
  task automatic reset_readback();
    foreach (all_addrs[i]) csr_cmd(CSR_OP_READ, all_addrs[i], '0);
  endtask

  task automatic random_rw();
    csr_addr_t a;
    csr_data_t w;
    repeat (200) begin
      a = rw_addrs[$urandom_range(0, 6)];
      w = rand_word();
      csr_cmd(csr_op_e'(w[1:0]), a, rand_word());
      csr_cmd(CSR_OP_READ, a, '0);
    end
  endtask

  task automatic illegal_accesses();
    csr_data_t w;
    csr_addr_t a;
    int        tries;
    repeat (60) begin
      tries = 0;
      w = rand_word();
      a = w[11:0];
      while (is_mapped(a) && tries < 16) begin   // bounded redraw
        w = rand_word();
        a = w[11:0];
        tries++;
      end
      if (is_mapped(a)) a = 12'h7FF;
      csr_cmd(csr_op_e'(w[13:12]), a, rand_word());
      csr_cmd(csr_op_e'(w[15:14] == 2'b00 ? 2'b01 : w[15:14]), CSR_MHARTID, rand_word());
      csr_cmd(CSR_OP_READ, rw_addrs[$urandom_range(0, 6)], '0);
    end
  endtask

  task automatic interrupt_pending();
    csr_data_t w;
    repeat (60) begin
      csr_cmd(CSR_OP_WRITE, CSR_MIE, rand_word());
      w = rand_word();
      irq_sw   = w[0];
      irq_tm   = w[1];
      irq_ext  = w[2];
      irq_fast = w[31:17];
      csr_cmd(CSR_OP_READ, CSR_MIP, '0);
    end
  endtask

  task automatic trap_and_mret();
    csr_data_t w;
    csr_cmd(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0008);   // mie on
    repeat (12) begin
      pc     = rand_word() & 32'hFFFF_FFFE;
      mtval  = rand_word();
      w      = rand_word();
      mcause = w[5:0];
      // trap entry against a same-cycle write that loses
      drive_cycle(1'b1, CSR_OP_WRITE, CSR_MEPC, rand_word(), 1'b1, 1'b0, 1'b0);
      csr_cmd(CSR_OP_READ, CSR_MEPC, '0);
      csr_cmd(CSR_OP_READ, CSR_MCAUSE, '0);
      csr_cmd(CSR_OP_READ, CSR_MTVAL, '0);
      csr_cmd(CSR_OP_READ, CSR_MSTATUS, '0);
      drive_cycle(1'b1, CSR_OP_WRITE, CSR_MSTATUS, '0, 1'b0, 1'b1, 1'b0);
      csr_cmd(CSR_OP_READ, CSR_MSTATUS, '0);
    end
  endtask

  task automatic counter_behavior();
    csr_cmd(CSR_OP_READ, CSR_MCYCLE, '0);
    idle_cycles($urandom_range(3, 40));
    csr_cmd(CSR_OP_READ, CSR_MCYCLE, '0);
    repeat (100) drive_cycle(1'b0, CSR_OP_READ, '0, '0, 1'b0, 1'b0, rand_bit());
    csr_cmd(CSR_OP_READ, CSR_MINSTRET, '0);
    csr_cmd(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h0000_0005);   // freeze both
    repeat (10) drive_cycle(1'b0, CSR_OP_READ, '0, '0, 1'b0, 1'b0, rand_bit());
    csr_cmd(CSR_OP_READ, CSR_MCYCLE, '0);
    csr_cmd(CSR_OP_READ, CSR_MINSTRET, '0);
    csr_cmd(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '0);
    repeat (4) begin
      csr_cmd(CSR_OP_WRITE, CSR_MCYCLE, rand_word());
      csr_cmd(CSR_OP_WRITE, CSR_MCYCLEH, rand_word());
      csr_cmd(CSR_OP_WRITE, CSR_MINSTRET, 32'hFFFF_FFFE);   // near a carry
      csr_cmd(CSR_OP_WRITE, CSR_MINSTRETH, rand_word());
      repeat (4) drive_cycle(1'b0, CSR_OP_READ, '0, '0, 1'b0, 1'b0, 1'b1);
      csr_cmd(CSR_OP_READ, CSR_MCYCLE, '0);
      csr_cmd(CSR_OP_READ, CSR_MCYCLEH, '0);
      csr_cmd(CSR_OP_READ, CSR_MINSTRET, '0);
      csr_cmd(CSR_OP_READ, CSR_MINSTRETH, '0);
    end
  endtask

  // run watchdog
  initial begin
    #2_000_000;
    $display("TIMEOUT: run did not complete within 2 ms");
    $display("Verification failed");
    $finish;
  end

  initial begin
    int errs;
    int waited;
    void'($urandom(13947));
    hart_id    = rand_word();
    csr_access = 1'b0;
    csr_addr   = '0;
    csr_op     = CSR_OP_READ;
    csr_wdata  = '0;
    irq_sw     = 1'b0;
    irq_tm     = 1'b0;
    irq_ext    = 1'b0;
    irq_fast   = '0;
    save_cause = 1'b0;
    mret       = 1'b0;
    instr_ret  = 1'b0;
    mcause     = '0;
    mtval      = '0;
    pc         = '0;

    // interrupt lines up while in reset, mie must hold them off
    @(posedge clk);
    #2;
    irq_sw   = 1'b1;
    irq_tm   = 1'b1;
    irq_ext  = 1'b1;
    irq_fast = '1;

    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      $display("Verification failed");
      $finish;
    end else begin
      errs = err_count;
      reset_readback();
      report_test("reset values", errs);
      errs = err_count;
      random_rw();
      report_test("write/set/clear", errs);
      errs = err_count;
      illegal_accesses();
      report_test("illegal access", errs);
      errs = err_count;
      interrupt_pending();
      report_test("mip and pending", errs);
      errs = err_count;
      trap_and_mret();
      report_test("trap and mret", errs);
      errs = err_count;
      counter_behavior();
      report_test("counters", errs);
      idle_cycles(2);

      $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
               tests_run, tests_failed, check_count, err_count);
      if (tests_failed == 0 && err_count == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

// ==== dv/csr_scoreboard.sv ====
// --------------------
// cycle model of the CSR file compared at every rising edge
// inputs must be stable at the edge, outputs are read before the flops move
// --------------------
`timescale 1ns/1ps

module csr_scoreboard import csr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  csr_data_t hart_id_i,
  input  logic      csr_access_i,
  input  csr_addr_t csr_addr_i,
  input  csr_op_e   csr_op_i,
  input  csr_data_t csr_wdata_i,
  input  csr_data_t csr_rdata_i,
  input  logic      illegal_csr_i,
  input  logic      irq_software_i,
  input  logic      irq_timer_i,
  input  logic      irq_external_i,
  input  fast_irq_t irq_fast_i,
  input  logic      irq_pending_i,
  input  logic      csr_save_cause_i,
  input  mcause_t   csr_mcause_i,
  input  csr_data_t csr_mtval_i,
  input  csr_data_t pc_i,
  input  logic      csr_restore_mret_i,
  input  logic      instr_ret_i,
  input  csr_data_t csr_mtvec_i,
  input  csr_data_t csr_mepc_i,
  input  logic      csr_mstatus_mie_i,
  output int        err_count_o,
  output int        check_count_o
);

  int        err_count = 0;
  int        check_count = 0;
  // model state
  logic      m_mie, m_mpie;
  csr_data_t m_ie, m_scratch, m_epc, m_tval, m_tvec;
  mcause_t   m_cause;
  counter_t  m_cycle, m_instret;
  logic      m_inh_cy, m_inh_ir;

  assign err_count_o   = err_count;
  assign check_count_o = check_count;

  function automatic csr_data_t enable_mask();
    csr_data_t m;
    m = '0;
    m[MSIX_BIT] = 1'b1;
    m[MTIX_BIT] = 1'b1;
    m[MEIX_BIT] = 1'b1;
    m[MFIX_LSB +: 15] = '1;
    return m;
  endfunction

  function automatic csr_data_t irq_lines();
    csr_data_t v;
    v = '0;
    v[MSIX_BIT] = irq_software_i;
    v[MTIX_BIT] = irq_timer_i;
    v[MEIX_BIT] = irq_external_i;
    v[MFIX_LSB +: 15] = irq_fast_i;
    return v;
  endfunction

  function automatic logic is_known(input csr_addr_t a);
    case (a)
      CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
      CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MCOUNTINHIBIT, CSR_MCYCLE,
      CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH, CSR_MHARTID: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic csr_data_t expected_read(input csr_addr_t a);
    csr_data_t r;
    r = '0;
    case (a)
      CSR_MSTATUS: begin
        r[MSTATUS_MIE_BIT]      = m_mie;
        r[MSTATUS_MPIE_BIT]     = m_mpie;
        r[MSTATUS_MPP_LSB +: 2] = 2'b11;
      end
      CSR_MISA:          r = MISA_VALUE;
      CSR_MIE:           r = m_ie;
      CSR_MTVEC:         r = m_tvec;
      CSR_MSCRATCH:      r = m_scratch;
      CSR_MEPC:          r = m_epc;
      CSR_MCAUSE:        r = {m_cause[5], 26'b0, m_cause[4:0]};
      CSR_MTVAL:         r = m_tval;
      CSR_MIP:           r = irq_lines() & m_ie;
      CSR_MCOUNTINHIBIT: r = {29'b0, m_inh_ir, 1'b0, m_inh_cy};
      CSR_MCYCLE:        r = m_cycle[31:0];
      CSR_MCYCLEH:       r = m_cycle[63:32];
      CSR_MINSTRET:      r = m_instret[31:0];
      CSR_MINSTRETH:     r = m_instret[63:32];
      CSR_MHARTID:       r = hart_id_i;
      default:           r = '0;
    endcase
    return r;
  endfunction

  task automatic compare_value(input string what, input csr_data_t got, input csr_data_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED @%0t: %s got %h expected %h (addr %h)",
               $time, what, got, exp, csr_addr_i);
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    logic      exp_illegal;
    logic      we;
    logic      cy_wr;
    logic      ir_wr;
    logic      old_mie;
    logic      old_mpie;
    csr_data_t old_val;
    csr_data_t new_val;
    if (!rst_ni) begin
      m_mie     = 1'b0;
      m_mpie    = 1'b0;
      m_ie      = '0;
      m_scratch = '0;
      m_epc     = '0;
      m_cause   = '0;
      m_tval    = '0;
      m_tvec    = MTVEC_RESET;
      m_cycle   = '0;
      m_instret = '0;
      m_inh_cy  = 1'b0;
      m_inh_ir  = 1'b0;
    end else begin
      exp_illegal = csr_access_i && (!is_known(csr_addr_i) ||
                    (csr_addr_i[11:10] == 2'b11 && csr_op_i != CSR_OP_READ));
      old_val = expected_read(csr_addr_i);

      // --------------------
      // compare
      compare_value("illegal_csr_o", {31'b0, illegal_csr_i}, {31'b0, exp_illegal});
      if (csr_access_i) compare_value("csr_rdata_o", csr_rdata_i, old_val);
      compare_value("irq_pending_o", {31'b0, irq_pending_i}, {31'b0, |(irq_lines() & m_ie)});
      compare_value("csr_mtvec_o", csr_mtvec_i, m_tvec);
      compare_value("csr_mepc_o", csr_mepc_i, m_epc);
      compare_value("csr_mstatus_mie_o", {31'b0, csr_mstatus_mie_i}, {31'b0, m_mie});

      // --------------------
      // advance model
      we       = csr_access_i && csr_op_i != CSR_OP_READ && !exp_illegal;
      cy_wr    = we && (csr_addr_i == CSR_MCYCLE || csr_addr_i == CSR_MCYCLEH);
      ir_wr    = we && (csr_addr_i == CSR_MINSTRET || csr_addr_i == CSR_MINSTRETH);
      old_mie  = m_mie;
      old_mpie = m_mpie;
      case (csr_op_i)
        CSR_OP_SET:   new_val = old_val | csr_wdata_i;
        CSR_OP_CLEAR: new_val = old_val & ~csr_wdata_i;
        default:      new_val = csr_wdata_i;
      endcase

      // counters step with the old inhibit bits unless written this cycle
      if (!m_inh_cy && !cy_wr) m_cycle = m_cycle + 64'd1;
      if (instr_ret_i && !m_inh_ir && !ir_wr) m_instret = m_instret + 64'd1;

      if (we) begin
        case (csr_addr_i)
          CSR_MSTATUS: begin
            m_mie  = new_val[MSTATUS_MIE_BIT];
            m_mpie = new_val[MSTATUS_MPIE_BIT];
          end
          CSR_MIE:           m_ie      = new_val & enable_mask();
          CSR_MTVEC:         m_tvec    = {new_val[31:8], 8'h01};
          CSR_MSCRATCH:      m_scratch = new_val;
          CSR_MEPC:          m_epc     = {new_val[31:1], 1'b0};
          CSR_MCAUSE:        m_cause   = {new_val[31], new_val[4:0]};
          CSR_MTVAL:         m_tval    = new_val;
          CSR_MCOUNTINHIBIT: begin
            m_inh_cy = new_val[0];
            m_inh_ir = new_val[2];
          end
          CSR_MCYCLE:        m_cycle[31:0]    = new_val;
          CSR_MCYCLEH:       m_cycle[63:32]   = new_val;
          CSR_MINSTRET:      m_instret[31:0]  = new_val;
          CSR_MINSTRETH:     m_instret[63:32] = new_val;
          default: ;
        endcase
      end

      if (csr_save_cause_i) begin
        m_epc   = pc_i;
        m_cause = csr_mcause_i;
        m_tval  = csr_mtval_i;
        m_mpie  = old_mie;
        m_mie   = 1'b0;
      end else if (csr_restore_mret_i) begin
        m_mie   = old_mpie;
        m_mpie  = 1'b1;
      end
    end
  end

endmodule

// ==== dv/tb_clk_gen.sv ====
// --------------------
// 40 ns clock, reset low for the first 4 rising edges
// --------------------
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #2 rst_no = 1'b1;   // release off the edge
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the CSR file testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module csr_file_tb -o csr_sim
./obj_dir/csr_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== sim.f ====
src/csr_pkg.sv
src/csr_access_ctrl.sv
src/csr_trap_regs.sv
src/csr_counters.sv
src/csr_file_top.sv
dv/tb_clk_gen.sv
dv/csr_scoreboard.sv
dv/csr_file_sva.sv
dv/csr_file_tb.sv

// ==== src/csr_access_ctrl.sv ====
// --------------------
// CSR access port decode and read/modify/write data
// read data and illegal flag are combinational, no stall
// address is decoded here only, blocks see csr_sel_o
// --------------------
`timescale 1ns/1ps

module csr_access_ctrl import csr_pkg::*; (
  input  logic      csr_access_i,
  input  csr_addr_t csr_addr_i,
  input  csr_op_e   csr_op_i,
  input  csr_data_t csr_wdata_i,
  input  csr_data_t hart_id_i,
  input  csr_data_t trap_rdata_i,
  input  csr_data_t cnt_rdata_i,
  output csr_sel_e  csr_sel_o,
  output logic      csr_we_o,
  output csr_data_t csr_wdata_o,
  output csr_data_t csr_rdata_o,
  output logic      illegal_csr_o
);

  logic      implemented;
  logic      read_only;
  logic      wr_req;
  csr_data_t const_rdata;

  // --------------------
  // address decode
  always_comb begin
    unique case (csr_addr_i)
      CSR_MSTATUS:       csr_sel_o = SEL_MSTATUS;
      CSR_MISA:          csr_sel_o = SEL_MISA;
      CSR_MIE:           csr_sel_o = SEL_MIE;
      CSR_MTVEC:         csr_sel_o = SEL_MTVEC;
      CSR_MCOUNTINHIBIT: csr_sel_o = SEL_MCOUNTINHIBIT;
      CSR_MSCRATCH:      csr_sel_o = SEL_MSCRATCH;
      CSR_MEPC:          csr_sel_o = SEL_MEPC;
      CSR_MCAUSE:        csr_sel_o = SEL_MCAUSE;
      CSR_MTVAL:         csr_sel_o = SEL_MTVAL;
      CSR_MIP:           csr_sel_o = SEL_MIP;
      CSR_MCYCLE:        csr_sel_o = SEL_MCYCLE;
      CSR_MCYCLEH:       csr_sel_o = SEL_MCYCLEH;
      CSR_MINSTRET:      csr_sel_o = SEL_MINSTRET;
      CSR_MINSTRETH:     csr_sel_o = SEL_MINSTRETH;
      CSR_MHARTID:       csr_sel_o = SEL_MHARTID;
      default:           csr_sel_o = SEL_NONE;
    endcase
  end

  assign implemented = (csr_sel_o != SEL_NONE);
  assign read_only   = (csr_addr_i[11:10] == 2'b11);  // standard read-only space
  assign wr_req      = (csr_op_i != CSR_OP_READ);

  assign illegal_csr_o = csr_access_i & (~implemented | (read_only & wr_req));
  assign csr_we_o      = csr_access_i & wr_req & ~illegal_csr_o;

  // --------------------
  // read data, blocks return zero for foreign selects
  always_comb begin
    const_rdata = '0;
    if (csr_sel_o == SEL_MHARTID) begin
      const_rdata = hart_id_i;
    end else if (csr_sel_o == SEL_MISA) begin
      const_rdata = MISA_VALUE;
    end
  end

  assign csr_rdata_o = trap_rdata_i | cnt_rdata_i | const_rdata;

  // write data from old value and op
  always_comb begin
    unique case (csr_op_i)
      CSR_OP_SET:   csr_wdata_o = csr_rdata_o | csr_wdata_i;
      CSR_OP_CLEAR: csr_wdata_o = csr_rdata_o & ~csr_wdata_i;
      default:      csr_wdata_o = csr_wdata_i;   // write, read ignores it
    endcase
  end

endmodule

// ==== src/csr_counters.sv ====
// --------------------
// mcycle, minstret and mcountinhibit
// a half write replaces 32 bits and skips that cycle's increment
// --------------------
`timescale 1ns/1ps

module csr_counters import csr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  csr_sel_e  csr_sel_i,
  input  logic      csr_we_i,
  input  csr_data_t csr_wdata_i,
  input  logic      instr_ret_i,
  output csr_data_t cnt_rdata_o
);

  counter_t mcycle_q, mcycle_d;
  counter_t minstret_q, minstret_d;
  logic     cy_inhibit_q, cy_inhibit_d;   // mcountinhibit[0]
  logic     ir_inhibit_q, ir_inhibit_d;   // mcountinhibit[2]

  always_comb begin
    mcycle_d     = mcycle_q;
    minstret_d   = minstret_q;
    cy_inhibit_d = cy_inhibit_q;
    ir_inhibit_d = ir_inhibit_q;

    if (csr_we_i && csr_sel_i == SEL_MCYCLE) begin
      mcycle_d[31:0] = csr_wdata_i;
    end else if (csr_we_i && csr_sel_i == SEL_MCYCLEH) begin
      mcycle_d[63:32] = csr_wdata_i;
    end else if (!cy_inhibit_q) begin
      mcycle_d = mcycle_q + 64'd1;
    end

    if (csr_we_i && csr_sel_i == SEL_MINSTRET) begin
      minstret_d[31:0] = csr_wdata_i;
    end else if (csr_we_i && csr_sel_i == SEL_MINSTRETH) begin
      minstret_d[63:32] = csr_wdata_i;
    end else if (instr_ret_i && !ir_inhibit_q) begin
      minstret_d = minstret_q + 64'd1;
    end

    if (csr_we_i && csr_sel_i == SEL_MCOUNTINHIBIT) begin
      cy_inhibit_d = csr_wdata_i[0];
      ir_inhibit_d = csr_wdata_i[2];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q     <= '0;
      minstret_q   <= '0;
      cy_inhibit_q <= 1'b0;
      ir_inhibit_q <= 1'b0;
    end else begin
      mcycle_q     <= mcycle_d;
      minstret_q   <= minstret_d;
      cy_inhibit_q <= cy_inhibit_d;
      ir_inhibit_q <= ir_inhibit_d;
    end
  end

  // read word
  always_comb begin
    unique case (csr_sel_i)
      SEL_MCOUNTINHIBIT: cnt_rdata_o = {29'b0, ir_inhibit_q, 1'b0, cy_inhibit_q};
      SEL_MCYCLE:        cnt_rdata_o = mcycle_q[31:0];
      SEL_MCYCLEH:       cnt_rdata_o = mcycle_q[63:32];
      SEL_MINSTRET:      cnt_rdata_o = minstret_q[31:0];
      SEL_MINSTRETH:     cnt_rdata_o = minstret_q[63:32];
      default:           cnt_rdata_o = '0;
    endcase
  end

endmodule

// ==== src/csr_file_top.sv ====
// --------------------
// machine-mode CSR file, SRAM-like access port
// no PMP, debug CSRs or hpm counters beyond mcycle/minstret
// --------------------
`timescale 1ns/1ps

module csr_file_top import csr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  csr_data_t hart_id_i,
  // access port
  input  logic      csr_access_i,
  input  csr_addr_t csr_addr_i,
  input  csr_op_e   csr_op_i,
  input  csr_data_t csr_wdata_i,
  output csr_data_t csr_rdata_o,
  output logic      illegal_csr_o,
  // interrupts
  input  logic      irq_software_i,
  input  logic      irq_timer_i,
  input  logic      irq_external_i,
  input  fast_irq_t irq_fast_i,
  output logic      irq_pending_o,
  // trap control
  input  logic      csr_save_cause_i,
  input  mcause_t   csr_mcause_i,
  input  csr_data_t csr_mtval_i,
  input  csr_data_t pc_i,
  input  logic      csr_restore_mret_i,
  input  logic      instr_ret_i,
  output csr_data_t csr_mtvec_o,
  output csr_data_t csr_mepc_o,
  output logic      csr_mstatus_mie_o
);

  csr_sel_e  csr_sel;
  logic      csr_we;
  csr_data_t csr_wdata;    // final write/set/clear value
  csr_data_t trap_rdata;
  csr_data_t cnt_rdata;

  csr_access_ctrl u_access_ctrl (
    .csr_access_i  (csr_access_i),
    .csr_addr_i    (csr_addr_i),
    .csr_op_i      (csr_op_i),
    .csr_wdata_i   (csr_wdata_i),
    .hart_id_i     (hart_id_i),
    .trap_rdata_i  (trap_rdata),
    .cnt_rdata_i   (cnt_rdata),
    .csr_sel_o     (csr_sel),
    .csr_we_o      (csr_we),
    .csr_wdata_o   (csr_wdata),
    .csr_rdata_o   (csr_rdata_o),
    .illegal_csr_o (illegal_csr_o)
  );

  csr_trap_regs u_trap_regs (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_sel_i          (csr_sel),
    .csr_we_i           (csr_we),
    .csr_wdata_i        (csr_wdata),
    .irq_software_i     (irq_software_i),
    .irq_timer_i        (irq_timer_i),
    .irq_external_i     (irq_external_i),
    .irq_fast_i         (irq_fast_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_mcause_i       (csr_mcause_i),
    .csr_mtval_i        (csr_mtval_i),
    .pc_i               (pc_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .trap_rdata_o       (trap_rdata),
    .csr_mtvec_o        (csr_mtvec_o),
    .csr_mepc_o         (csr_mepc_o),
    .csr_mstatus_mie_o  (csr_mstatus_mie_o),
    .irq_pending_o      (irq_pending_o)
  );

  csr_counters u_counters (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_sel_i   (csr_sel),
    .csr_we_i    (csr_we),
    .csr_wdata_i (csr_wdata),
    .instr_ret_i (instr_ret_i),
    .cnt_rdata_o (cnt_rdata)
  );

endmodule

// ==== src/csr_pkg.sv ====
// --------------------
// machine-mode CSR definitions for a single RV32 hart
// only M-mode exists, so mstatus.mpp always reads as 3
// --------------------
package csr_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [63:0] counter_t;
  typedef logic [5:0]  mcause_t;    // {interrupt, code[4:0]}
  typedef logic [14:0] fast_irq_t;

  typedef enum logic [1:0] {
    CSR_OP_READ,
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_e;

  // decoded register select, one value per implemented CSR
  typedef enum logic [4:0] {
    SEL_NONE,
    SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC, SEL_MSCRATCH,
    SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP, SEL_MCOUNTINHIBIT,
    SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH, SEL_MHARTID
  } csr_sel_e;

  // --------------------
  // CSR addresses
  localparam csr_addr_t CSR_MSTATUS       = 12'h300;
  localparam csr_addr_t CSR_MISA          = 12'h301;
  localparam csr_addr_t CSR_MIE           = 12'h304;
  localparam csr_addr_t CSR_MTVEC         = 12'h305;
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
  localparam csr_addr_t CSR_MEPC          = 12'h341;
  localparam csr_addr_t CSR_MCAUSE        = 12'h342;
  localparam csr_addr_t CSR_MTVAL         = 12'h343;
  localparam csr_addr_t CSR_MIP           = 12'h344;
  localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;
  localparam csr_addr_t CSR_MHARTID       = 12'hF14;

  // --------------------
  // bit positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;
  localparam int unsigned MSIX_BIT         = 3;
  localparam int unsigned MTIX_BIT         = 7;
  localparam int unsigned MEIX_BIT         = 11;
  localparam int unsigned MFIX_LSB         = 16;   // 15 fast lines, bits 30:16

  localparam csr_data_t MISA_VALUE  = 32'h4000_0104;  // MXL=1, I, C
  localparam csr_data_t MTVEC_RESET = 32'h0000_0001;  // vectored, base 0

endpackage

// ==== src/csr_trap_regs.sv ====
// --------------------
// trap and interrupt CSRs
// trap entry beats MRET, both beat a CSR write in the same cycle
// mip is combinational from the irq inputs and mie
// --------------------
`timescale 1ns/1ps

module csr_trap_regs import csr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  csr_sel_e  csr_sel_i,
  input  logic      csr_we_i,
  input  csr_data_t csr_wdata_i,
  input  logic      irq_software_i,
  input  logic      irq_timer_i,
  input  logic      irq_external_i,
  input  fast_irq_t irq_fast_i,
  input  logic      csr_save_cause_i,
  input  mcause_t   csr_mcause_i,
  input  csr_data_t csr_mtval_i,
  input  csr_data_t pc_i,
  input  logic      csr_restore_mret_i,
  output csr_data_t trap_rdata_o,
  output csr_data_t csr_mtvec_o,
  output csr_data_t csr_mepc_o,
  output logic      csr_mstatus_mie_o,
  output logic      irq_pending_o
);

  logic      mstatus_mie_q, mstatus_mie_d;
  logic      mstatus_mpie_q, mstatus_mpie_d;
  csr_data_t mie_q, mie_d;        // only enable bit positions held
  csr_data_t mip;
  csr_data_t irq_vec;
  csr_data_t mie_mask;
  csr_data_t mscratch_q, mscratch_d;
  csr_data_t mepc_q, mepc_d;
  mcause_t   mcause_q, mcause_d;
  csr_data_t mtval_q, mtval_d;
  csr_data_t mtvec_q, mtvec_d;

  // --------------------
  // interrupt lines placed at their mip/mie positions
  always_comb begin
    irq_vec                      = '0;
    irq_vec[MSIX_BIT]            = irq_software_i;
    irq_vec[MTIX_BIT]            = irq_timer_i;
    irq_vec[MEIX_BIT]            = irq_external_i;
    irq_vec[MFIX_LSB +: 15]      = irq_fast_i;
    mie_mask                     = '0;
    mie_mask[MSIX_BIT]           = 1'b1;
    mie_mask[MTIX_BIT]           = 1'b1;
    mie_mask[MEIX_BIT]           = 1'b1;
    mie_mask[MFIX_LSB +: 15]     = '1;
  end

  assign mip           = irq_vec & mie_q;
  assign irq_pending_o = |mip;

  // --------------------
  // next state
  always_comb begin
    mstatus_mie_d  = mstatus_mie_q;
    mstatus_mpie_d = mstatus_mpie_q;
    mie_d          = mie_q;
    mscratch_d     = mscratch_q;
    mepc_d         = mepc_q;
    mcause_d       = mcause_q;
    mtval_d        = mtval_q;
    mtvec_d        = mtvec_q;

    if (csr_we_i) begin
      unique case (csr_sel_i)
        SEL_MSTATUS: begin
          mstatus_mie_d  = csr_wdata_i[MSTATUS_MIE_BIT];
          mstatus_mpie_d = csr_wdata_i[MSTATUS_MPIE_BIT];
        end
        SEL_MIE:      mie_d      = csr_wdata_i & mie_mask;
        SEL_MSCRATCH: mscratch_d = csr_wdata_i;
        SEL_MEPC:     mepc_d     = {csr_wdata_i[31:1], 1'b0};
        SEL_MCAUSE:   mcause_d   = {csr_wdata_i[31], csr_wdata_i[4:0]};
        SEL_MTVAL:    mtval_d    = csr_wdata_i;
        SEL_MTVEC:    mtvec_d    = {csr_wdata_i[31:8], 8'h01};  // vectored only
        default: ;
      endcase
    end

    if (csr_save_cause_i) begin
      mepc_d         = pc_i;
      mcause_d       = csr_mcause_i;
      mtval_d        = csr_mtval_i;
      mstatus_mpie_d = mstatus_mie_q;
      mstatus_mie_d  = 1'b0;   // mask interrupts in handler
    end else if (csr_restore_mret_i) begin
      mstatus_mie_d  = mstatus_mpie_q;
      mstatus_mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
      mtvec_q        <= MTVEC_RESET;
    end else begin
      mstatus_mie_q  <= mstatus_mie_d;
      mstatus_mpie_q <= mstatus_mpie_d;
      mie_q          <= mie_d;
      mscratch_q     <= mscratch_d;
      mepc_q         <= mepc_d;
      mcause_q       <= mcause_d;
      mtval_q        <= mtval_d;
      mtvec_q        <= mtvec_d;
    end
  end

  // --------------------
  // read word, zero for selects owned elsewhere
  always_comb begin
    trap_rdata_o = '0;
    unique case (csr_sel_i)
      SEL_MSTATUS: begin
        trap_rdata_o[MSTATUS_MIE_BIT]          = mstatus_mie_q;
        trap_rdata_o[MSTATUS_MPIE_BIT]         = mstatus_mpie_q;
        trap_rdata_o[MSTATUS_MPP_LSB +: 2]     = 2'b11;   // always M-mode
      end
      SEL_MIE:      trap_rdata_o = mie_q;
      SEL_MIP:      trap_rdata_o = mip;
      SEL_MSCRATCH: trap_rdata_o = mscratch_q;
      SEL_MEPC:     trap_rdata_o = mepc_q;
      SEL_MCAUSE:   trap_rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      SEL_MTVAL:    trap_rdata_o = mtval_q;
      SEL_MTVEC:    trap_rdata_o = mtvec_q;
      default: ;
    endcase
  end

  assign csr_mtvec_o       = mtvec_q;
  assign csr_mepc_o        = mepc_q;
  assign csr_mstatus_mie_o = mstatus_mie_q;

endmodule
